//--- filelist.f
src/legBusPkg.sv
src/busDecoder.sv
src/dataMem.sv
src/gpioPort.sv
src/memSubsystem.sv
tb/memSubsystemTb.sv

//--- src/busDecoder.sv
// address and legality decode for the single-master data bus
// raises one slave select per legal access and flags everything else as an error
// fully combinational so the response settles in the request cycle

`timescale 1ns/1ps

module busDecoder #(
  parameter int memWords = 1024
) (
  input  logic        rstN,
  input  logic [31:0] addr,
  input  logic [1:0]  size,
  input  logic        we,
  input  logic        re,
  input  logic [31:0] memRdata,
  input  logic [31:0] gpioRdata,
  output logic        memSel,
  output logic        gpioSel,
  output logic [31:0] rdata,
  output logic        valid,
  output logic        error
);

  logic active;
  logic sizeOk;
  logic alignOk;
  logic memHit;
  logic gpioWin;
  logic gpioOff;
  logic legal;

  // no request is honoured while reset is held
  assign active = rstN & (re | we);

  assign sizeOk = (size != legBusPkg::sizeRsvd);

  // halfwords on even bytes and words on word boundaries
  always_comb begin
    case (size)
      legBusPkg::sizeHalf: alignOk = ~addr[0];
      legBusPkg::sizeWord: alignOk = (addr[1:0] == 2'b00);
      default: alignOk = 1'b1;
    endcase
  end

  // memory starts at 0 and holds memWords words
  assign memHit = ({2'b00, addr[31:2]} < 32'(memWords));

  // gpio window and one of the two defined words inside it
  assign gpioWin = (addr[31:16] == legBusPkg::gpioBase[31:16]);
  assign gpioOff = ({addr[15:2], 2'b00} == legBusPkg::gpioOutOffset) ||
                   ({addr[15:2], 2'b00} == legBusPkg::gpioInOffset);

  assign legal = sizeOk & alignOk & (memHit | (gpioWin & gpioOff));

  // one-hot selects for legal accesses only
  assign memSel = active & legal & memHit;
  assign gpioSel = active & legal & gpioWin & gpioOff;

  assign valid = memSel | gpioSel;
  assign error = active & ~legal;

  // read return mux gives zero unless a legal read is in flight
  always_comb begin
    rdata = '0;
    if (re && memSel) begin
      rdata = memRdata;
    end else if (re && gpioSel) begin
      rdata = gpioRdata;
    end
  end

  // the two slave windows must never overlap for any memWords
  always_comb begin
    selOneHot: assert final (!(memSel && gpioSel))
      else $error("memory and gpio selected together at addr %h", addr);
  end

endmodule

//--- src/dataMem.sv
// byte-addressable data memory, one 32-bit word per entry
// the addressed word is read combinationally every cycle
// selected writes land on the next rising clk edge and touch only the sized lanes

`timescale 1ns/1ps

module dataMem #(
  parameter int memWords = 1024
) (
  input  logic        clk,
  input  logic        sel,
  input  logic        we,
  input  logic [1:0]  size,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  // word index width, at least one bit so a tiny memory still builds
  localparam int idxBits = (memWords > 1) ? $clog2(memWords) : 1;

  logic [31:0] mem [memWords];
  logic [idxBits-1:0] wordIdx;
  logic [31:0] mergedWord;
  logic doWrite;

  // byte address to word index, lane bits dropped
  // the decoder has already range-checked the address
  assign wordIdx = addr[idxBits+1:2];

  // whole aligned word goes back, the core picks its lanes
  assign rdata = mem[wordIdx];

  // untouched lanes come from the current contents
  assign mergedWord = legBusPkg::mergeLanes(rdata, wdata, size, addr[1:0]);

  assign doWrite = sel & we;

  // contents are not reset
  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wordIdx] <= mergedWord;
    end
  end

  // decoder filters reserved sizes before they reach the memory
  rsvdNeverWritten: assert property (@(posedge clk)
    (sel && we) |-> (size != legBusPkg::sizeRsvd))
    else $error("memory write with reserved size at addr %h", addr);

endmodule

//--- src/gpioPort.sv
// general-purpose I/O slave on the data bus
// offset 0 is a byte-writable output register whose low byte drives the pins
// offset 4 reads the input pins after a two-flop synchroniser

`timescale 1ns/1ps

module gpioPort (
  input  logic        clk,
  input  logic        rstN,
  input  logic        sel,
  input  logic        we,
  input  logic [1:0]  size,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [7:0]  pinsIn,
  output logic [31:0] rdata,
  output logic [7:0]  pinsOut
);

  logic [31:0] outReg;
  logic [7:0] syncMeta;
  logic [7:0] syncIn;
  logic isOut;
  logic isIn;

  // word offset inside the window, lane bits ignored
  assign isOut = ({addr[15:2], 2'b00} == legBusPkg::gpioOutOffset);
  assign isIn = ({addr[15:2], 2'b00} == legBusPkg::gpioInOffset);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outReg <= '0;
      syncMeta <= '0;
      syncIn <= '0;
    end else begin
      // pins are asynchronous, two stages before anyone reads them
      syncMeta <= pinsIn;
      syncIn <= syncMeta;
      // only the output word is writable, stores to offset 4 fall away
      if (sel && we && isOut) begin
        outReg <= legBusPkg::mergeLanes(outReg, wdata, size, addr[1:0]);
      end
    end
  end

  // input word zero-extended, otherwise the output register
  always_comb begin
    if (isIn) begin
      rdata = {24'h0, syncIn};
    end else begin
      rdata = outReg;
    end
  end

  // pins follow the register directly
  assign pinsOut = outReg[7:0];

  // word accesses are aligned by the decoder
  wordAligned: assert property (@(posedge clk) disable iff (!rstN)
    (sel && size == legBusPkg::sizeWord) |-> (addr[1:0] == 2'b00))
    else $error("misaligned word access reached gpio at addr %h", addr);

endmodule

//--- src/legBusPkg.sv
// shared definitions for the data-memory bus
// address map, transfer-size codes and the byte-lane merge used by both slaves
// referenced by scoped name from each module that needs it

package legBusPkg;

  // transfer size, low two bits of HSIZE
  localparam logic [1:0] sizeByte = 2'b00;
  localparam logic [1:0] sizeHalf = 2'b01;
  localparam logic [1:0] sizeWord = 2'b10;
  localparam logic [1:0] sizeRsvd = 2'b11;

  // gpio window is selected by the upper 16 address bits
  localparam logic [31:0] gpioBase = 32'h4000_0000;
  // byte offsets of the two gpio words inside the window
  localparam logic [15:0] gpioOutOffset = 16'h0000;
  localparam logic [15:0] gpioInOffset = 16'h0004;

  // one bus word, seen as byte lanes or as halfword lanes
  typedef union packed {
    logic [3:0][7:0] bytes;
    logic [1:0][15:0] halves;
  } laneWord_t;

  // write data arrives already placed on its lanes, as on AHB
  // only the addressed lanes are taken from it
  function automatic logic [31:0] mergeLanes(logic [31:0] oldWord, logic [31:0] newData,
                                             logic [1:0] size, logic [1:0] lowAddr);
    laneWord_t merged;
    laneWord_t src;
    merged = oldWord;
    src = newData;
    case (size)
      sizeByte: merged.bytes[lowAddr] = src.bytes[lowAddr];
      sizeHalf: merged.halves[lowAddr[1]] = src.halves[lowAddr[1]];
      sizeWord: merged = src;
      // reserved size never reaches a slave, keep the old word anyway
      default: merged = oldWord;
    endcase
    return merged;
  endfunction

endpackage

//--- src/memSubsystem.sv
// top of the data-memory subsystem
// a single bus master reaches the data memory and the gpio block through the decoder
// memWords sets the memory depth and is passed to the decoder and the memory

`timescale 1ns/1ps

module memSubsystem #(
  parameter int memWords = 1024
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] addr,
  input  logic [1:0]  size,
  input  logic        we,
  input  logic        re,
  input  logic [31:0] wdata,
  input  logic [7:0]  gpioIn,
  output logic [31:0] rdata,
  output logic        valid,
  output logic        error,
  output logic [7:0]  gpioOut
);

  logic memSel;
  logic gpioSel;
  logic [31:0] memRdata;
  logic [31:0] gpioRdata;

  // routes each request and muxes the response back
  busDecoder #(
    .memWords(memWords)
  ) i_decoder (
    .rstN(rstN),
    .addr(addr),
    .size(size),
    .we(we),
    .re(re),
    .memRdata(memRdata),
    .gpioRdata(gpioRdata),
    .memSel(memSel),
    .gpioSel(gpioSel),
    .rdata(rdata),
    .valid(valid),
    .error(error)
  );

  dataMem #(
    .memWords(memWords)
  ) i_mem (
    .clk(clk),
    .sel(memSel),
    .we(we),
    .size(size),
    .addr(addr),
    .wdata(wdata),
    .rdata(memRdata)
  );

  // gpio needs reset for its register and synchroniser
  gpioPort i_gpio (
    .clk(clk),
    .rstN(rstN),
    .sel(gpioSel),
    .we(we),
    .size(size),
    .addr(addr),
    .wdata(wdata),
    .pinsIn(gpioIn),
    .rdata(gpioRdata),
    .pinsOut(gpioOut)
  );

endmodule

//--- tb/memSubsystemTb.sv
// testbench for the data-memory subsystem
// replays tb/memSubsystem_golden.dat one bus transfer per clock and checks every response
// run from the project root so the golden file path resolves

`timescale 1ns/1ps

module memSubsystemTb;

  localparam int halfPeriod = 20;
  localparam int clkPeriod = 2 * halfPeriod;
  localparam int resetCycles = 10;
  // slack on top of the golden length for the watchdog
  localparam int marginCycles = 20;
  localparam logic [31:0] rngSeed = 32'hb282_8ab6;
  localparam string goldenPath = "tb/memSubsystem_golden.dat";

  logic        clk;
  logic        rstN;
  logic [31:0] addr;
  logic [1:0]  size;
  logic        we;
  logic        re;
  logic [31:0] wdata;
  logic [7:0]  gpioIn;
  logic [31:0] rdata;
  logic        valid;
  logic        error;
  logic [7:0]  gpioOut;

  // golden transactions with one entry per file line
  string       nameQ[$];
  string       opQ[$];
  logic [31:0] addrQ[$];
  logic [1:0]  sizeQ[$];
  logic [31:0] wdataQ[$];
  logic [7:0]  pinQ[$];
  logic [31:0] expRdataQ[$];
  logic        expErrQ[$];
  logic [7:0]  expOutQ[$];

  bit loaded = 1'b0;
  int watchdogNs = 0;

  memSubsystem i_dut (
    .clk(clk),
    .rstN(rstN),
    .addr(addr),
    .size(size),
    .we(we),
    .re(re),
    .wdata(wdata),
    .gpioIn(gpioIn),
    .rdata(rdata),
    .valid(valid),
    .error(error),
    .gpioOut(gpioOut)
  );

  always #halfPeriod clk = ~clk;

  // print the reason and stop the run
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkField(input string testName, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      abortRun($sformatf("Mismatch in %s: %s expected %h actual %h",
                         testName, field, expected, actual));
    end
  endtask

  // lines starting with '#' are skipped and every other line is one transaction
  task automatic loadGolden();
    int fd;
    int code;
    bit more;
    string tok;
    string opTok;
    logic [31:0] a;
    logic [1:0] s;
    logic [31:0] w;
    logic [7:0] pin;
    logic [31:0] r;
    logic e;
    logic [7:0] po;
    logic [8*256-1:0] rest;
    fd = $fopen(goldenPath, "r");
    if (fd == 0) begin
      abortRun($sformatf("could not open the golden file %s", goldenPath));
    end else begin
      more = 1'b1;
      while (more) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) begin
          more = 1'b0;
        end else if (tok[0] == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%s %h %h %h %h %h %h %h", opTok, a, s, w, pin, r, e, po);
          if (code != 8) begin
            abortRun($sformatf("golden line %s has missing or unreadable fields", tok));
          end else if (opTok != "W" && opTok != "R" && opTok != "I") begin
            abortRun($sformatf("golden line %s has an unknown operation %s", tok, opTok));
          end else begin
            nameQ.push_back(tok);
            opQ.push_back(opTok);
            addrQ.push_back(a);
            sizeQ.push_back(s);
            wdataQ.push_back(w);
            pinQ.push_back(pin);
            expRdataQ.push_back(r);
            expErrQ.push_back(e);
            expOutQ.push_back(po);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // quiet bus with random data on the unused write bus
  task automatic driveIdle(input logic [31:0] idleAddr, input logic [1:0] idleSize);
    we = 1'b0;
    re = 1'b0;
    addr = idleAddr;
    size = idleSize;
    wdata = $urandom;
  endtask

  // reset held low while a read attempt in the middle must be ignored
  task automatic applyReset();
    int cyc;
    for (cyc = 0; cyc < resetCycles; cyc++) begin
      @(negedge clk);
      driveIdle(32'h0, legBusPkg::sizeWord);
      // pins move while the synchroniser is held in reset
      gpioIn = $urandom;
      if (cyc == resetCycles / 2) begin
        re = 1'b1;
        addr = legBusPkg::gpioBase;
      end
      #(halfPeriod - 1);
      checkField("resetHold", "valid", 32'(1'b0), 32'(valid));
      checkField("resetHold", "error", 32'(1'b0), 32'(error));
    end
  endtask

  // one golden line per clock checked just before the next rising edge
  task automatic runLine(input int idx);
    logic expValid;
    @(negedge clk);
    rstN = 1'b1;
    gpioIn = pinQ[idx];
    if (opQ[idx] == "W") begin
      we = 1'b1;
      re = 1'b0;
      addr = addrQ[idx];
      size = sizeQ[idx];
      wdata = wdataQ[idx];
    end else if (opQ[idx] == "R") begin
      we = 1'b0;
      re = 1'b1;
      addr = addrQ[idx];
      size = sizeQ[idx];
      wdata = wdataQ[idx];
    end else begin
      driveIdle(addrQ[idx], sizeQ[idx]);
    end
    // valid only for a legal request
    expValid = (opQ[idx] != "I") && !expErrQ[idx];
    #(halfPeriod - 1);
    checkField(nameQ[idx], "rdata", expRdataQ[idx], rdata);
    checkField(nameQ[idx], "error", 32'(expErrQ[idx]), 32'(error));
    checkField(nameQ[idx], "valid", 32'(expValid), 32'(valid));
    checkField(nameQ[idx], "gpioOut", 32'(expOutQ[idx]), 32'(gpioOut));
  endtask

  initial begin
    int i;
    clk = 1'b0;
    rstN = 1'b0;
    addr = '0;
    size = '0;
    we = 1'b0;
    re = 1'b0;
    wdata = '0;
    gpioIn = '0;
    void'($urandom(rngSeed));
    loadGolden();
    if (nameQ.size() == 0) begin
      abortRun("the golden file holds no transactions");
    end
    watchdogNs = (nameQ.size() + resetCycles + marginCycles) * clkPeriod;
    loaded = 1'b1;
    applyReset();
    for (i = 0; i < nameQ.size(); i++) begin
      runLine(i);
    end
    $display("Test completed successfully");
    $finish;
  end

  // limit set from the golden length once it is known
  initial begin
    wait (loaded);
    #(watchdogNs);
    $display("timeout: the run did not finish within %0d ns", watchdogNs);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- tb/memSubsystem_golden.dat
# name op addr size wdata gpioIn expRdata expError expGpioOut, numbers in hex
# op W write, R read, I idle; size 0 byte, 1 half, 2 word, 3 reserved
rstGpioOut R 40000000 2 00000000 00 00000000 0 00
rstGpioIn R 40000004 2 00000000 00 00000000 0 00
wordWr0 W 00000000 2 deadbeef 00 00000000 0 00
wordRd0 R 00000000 2 00000000 00 deadbeef 0 00
wordWr1 W 00000ffc 2 12345678 00 00000000 0 00
wordRd1 R 00000ffc 2 00000000 00 12345678 0 00
wordWr2 W 00000100 2 a5a5a5a5 00 00000000 0 00
wordRd2 R 00000100 2 00000000 00 a5a5a5a5 0 00
subBase W 00000010 2 11223344 00 00000000 0 00
byteWr0 W 00000010 0 555555aa 00 00000000 0 00
byteRd0 R 00000010 2 00000000 00 112233aa 0 00
byteWr1 W 00000011 0 0000bb00 00 00000000 0 00
byteRd1 R 00000010 2 00000000 00 1122bbaa 0 00
byteWr2 W 00000012 0 00cc0000 00 00000000 0 00
byteRd2 R 00000010 2 00000000 00 11ccbbaa 0 00
byteWr3 W 00000013 0 dd000000 00 00000000 0 00
byteRd3 R 00000010 2 00000000 00 ddccbbaa 0 00
halfWrLo W 00000010 1 1234beef 00 00000000 0 00
halfRdLo R 00000010 2 00000000 00 ddccbeef 0 00
halfWrHi W 00000012 1 cafe9999 00 00000000 0 00
halfRdHi R 00000010 2 00000000 00 cafebeef 0 00
byteRdWhole R 00000011 0 00000000 00 cafebeef 0 00
illBase W 00000020 2 0f0f0f0f 00 00000000 0 00
rsvdWr W 00000020 3 ffffffff 00 00000000 1 00
rsvdRd R 00000020 3 00000000 00 00000000 1 00
misHalfWr W 00000021 1 ffffffff 00 00000000 1 00
misWordWr W 00000022 2 ffffffff 00 00000000 1 00
misWordRd R 00000021 2 00000000 00 00000000 1 00
illMemChk R 00000020 2 00000000 00 0f0f0f0f 0 00
rangeWr W 00001000 2 ffffffff 00 00000000 1 00
rangeRd R 00001000 2 00000000 00 00000000 1 00
gpioOffRd R 40000008 2 00000000 00 00000000 1 00
gpioOffWr W 40000010 2 000000ff 00 00000000 1 00
unmappedRd R 80000000 2 00000000 00 00000000 1 00
illGpioChk R 40000000 2 00000000 00 00000000 0 00
gpioWordWr W 40000000 2 87654321 00 00000000 0 00
gpioWordRd R 40000000 2 00000000 00 87654321 0 21
gpioByteWr0 W 40000000 0 000000a5 00 00000000 0 21
gpioByteRd0 R 40000000 2 00000000 00 876543a5 0 a5
gpioByteWr1 W 40000001 0 0000ee00 00 00000000 0 a5
gpioByteRd1 R 40000000 2 00000000 00 8765eea5 0 a5
gpioHalfWr W 40000002 1 0bad0000 00 00000000 0 a5
gpioHalfRd R 40000000 2 00000000 00 0badeea5 0 a5
pinSet I 00000000 0 00000000 3c 00000000 0 a5
pinWait I 00000000 0 00000000 3c 00000000 0 a5
pinRd R 40000004 2 00000000 3c 0000003c 0 a5
pinInWr W 40000004 2 ffffffff 3c 00000000 0 a5
pinRdAgain R 40000004 2 00000000 3c 0000003c 0 a5
pinOutChk R 40000000 2 00000000 3c 0badeea5 0 a5
pinChange I 00000000 0 00000000 c3 00000000 0 a5
pinWait2 I 00000000 0 00000000 c3 00000000 0 a5
pinRd2 R 40000004 2 00000000 c3 000000c3 0 a5
pinRdByte R 40000005 0 00000000 c3 000000c3 0 a5
